//--- rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// first fetch address out of reset
`define RV_RESET_PC 32'h8000_0000

// architectural integer registers
`define RV_NUM_REGS 32

// full encoding, ebreak has no operand bits
`define RV_EBREAK 32'h0010_0073

`endif

//--- rv_pkg.sv
package rv_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_type_t;

    // branch offset bits are scattered, bit 0 is implied
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    typedef union packed {
        logic [31:0] raw;
        r_type_t     r;
        i_type_t     i;
        s_type_t     s;
        b_type_t     b;
        u_type_t     u;
        j_type_t     j;
    } inst_u;

endpackage

//--- dec_exec_if.sv
`timescale 1ns/1ps

interface dec_exec_if import rv_pkg::*; ();
    alu_op_e     alu_op;
    logic [31:0] imm;       // already sign extended
    logic [2:0]  funct3;    // branch condition select
    logic        use_imm;
    logic        use_pc_a;
    logic        is_branch;
    logic        is_jal;
    logic        is_jalr;
    logic        reg_wen;
    logic        is_ebreak;
    logic        is_lui;

    modport dec (
        output alu_op, imm, funct3, use_imm, use_pc_a,
        output is_branch, is_jal, is_jalr, reg_wen, is_ebreak, is_lui
    );

    modport exe (
        input alu_op, imm, funct3, use_imm, use_pc_a,
        input is_branch, is_jal, is_jalr, reg_wen, is_ebreak, is_lui
    );

endinterface

//--- inst_decoder.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module inst_decoder import rv_pkg::*; (
    input  logic [31:0] inst,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    dec_exec_if.dec     dx
);

    inst_u   iw;
    opcode_e opc;
    logic    alt;  // funct7 bit 5 selects sub / sra

    assign iw.raw = inst;
    assign opc    = iw.r.opcode;
    assign rs1    = iw.r.rs1;
    assign rs2    = iw.r.rs2;
    assign rd     = iw.r.rd;
    assign alt    = iw.r.funct7[5];

    assign dx.funct3 = iw.r.funct3;

    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic sel_alt);
        case (f3)
            3'b000:  return sel_alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return sel_alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    // immediate, one view of the word per format
    always_comb
    begin
        case (opc)
            OPC_OP_IMM, OPC_JALR: dx.imm = {{20{iw.i.imm[11]}}, iw.i.imm};
            OPC_BRANCH: dx.imm = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11,
                                  iw.b.imm10_5, iw.b.imm4_1, 1'b0};
            OPC_LUI, OPC_AUIPC: dx.imm = {iw.u.imm, 12'b0};
            OPC_JAL: dx.imm = {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12,
                               iw.j.imm11, iw.j.imm10_1, 1'b0};
            default: dx.imm = '0;
        endcase
    end

    always_comb
    begin
        dx.alu_op    = ADD;
        dx.use_imm   = 1'b0;
        dx.use_pc_a  = 1'b0;
        dx.is_branch = 1'b0;
        dx.is_jal    = 1'b0;
        dx.is_jalr   = 1'b0;
        dx.reg_wen   = 1'b0;
        dx.is_ebreak = 1'b0;
        dx.is_lui    = 1'b0;
        case (opc)
            OPC_OP:
            begin
                dx.alu_op  = alu_from_f3(iw.r.funct3, alt);
                dx.reg_wen = 1'b1;
            end
            OPC_OP_IMM:
            begin
                // only srai looks at funct7, addi has imm bits there
                dx.alu_op  = alu_from_f3(iw.r.funct3, alt && iw.r.funct3 == 3'b101);
                dx.use_imm = 1'b1;
                dx.reg_wen = 1'b1;
            end
            OPC_LUI:
            begin
                dx.alu_op  = PASS_B;
                dx.use_imm = 1'b1;
                dx.is_lui  = 1'b1;
                dx.reg_wen = 1'b1;
            end
            OPC_AUIPC, OPC_JAL:
            begin
                dx.use_imm  = 1'b1;
                dx.use_pc_a = 1'b1;
                dx.is_jal   = (opc == OPC_JAL);
                dx.reg_wen  = 1'b1;
            end
            OPC_JALR:
            begin
                dx.use_imm = 1'b1;
                dx.is_jalr = 1'b1;
                dx.reg_wen = 1'b1;
            end
            OPC_BRANCH: dx.is_branch = 1'b1;
            OPC_SYSTEM: dx.is_ebreak = (inst == `RV_EBREAK);  // other system ops are no-ops
            default: ;
        endcase
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        wen,
    input  logic [31:0] rd_value,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value,
    output logic [31:0] a0_value
);

    logic [31:0] regs [`RV_NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            for (int i = 0; i < `RV_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wen && rd != '0)
        begin
            regs[rd] <= rd_value;
        end
    end

    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];
    assign a0_value  = regs[10];  // x10, return value at ebreak

    // x0 reads zero whatever was written to it
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst)
        (rs1 == '0) |-> (rs1_value == '0))
        else $error("x0 read back nonzero");

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit import rv_pkg::*; (
    input  logic [31:0] pc,
    input  logic [31:0] rs1_value,
    input  logic [31:0] rs2_value,
    dec_exec_if.exe     dx,
    output logic [31:0] wb_value,
    output logic [31:0] next_pc
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [31:0] pc_plus4;
    logic [31:0] pc_imm;
    logic [4:0]  shamt;
    logic        take_branch;

    assign op_a     = dx.use_pc_a ? pc : rs1_value;
    assign op_b     = dx.use_imm ? dx.imm : rs2_value;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = pc + 32'd4;
    assign pc_imm   = pc + dx.imm;  // branch target

    always_comb
    begin
        case (dx.alu_op)
            ADD:     alu_result = op_a + op_b;
            SUB:     alu_result = op_a - op_b;
            SLL:     alu_result = op_a << shamt;
            SLT:     alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            SLTU:    alu_result = {31'b0, op_a < op_b};
            XOR:     alu_result = op_a ^ op_b;
            SRL:     alu_result = op_a >> shamt;
            SRA:     alu_result = $unsigned($signed(op_a) >>> shamt);
            OR:      alu_result = op_a | op_b;
            AND:     alu_result = op_a & op_b;
            default: alu_result = op_b;  // pass_b
        endcase
    end

    // compare on the register values, not the alu operands
    always_comb
    begin
        case (dx.funct3)
            3'b000:  take_branch = (rs1_value == rs2_value);
            3'b001:  take_branch = (rs1_value != rs2_value);
            3'b100:  take_branch = ($signed(rs1_value) < $signed(rs2_value));
            3'b101:  take_branch = ($signed(rs1_value) >= $signed(rs2_value));
            3'b110:  take_branch = (rs1_value < rs2_value);
            3'b111:  take_branch = (rs1_value >= rs2_value);
            default: take_branch = 1'b0;
        endcase
    end

    always_comb
    begin
        if (dx.is_ebreak)
            next_pc = pc;  // park on the ebreak
        else if (dx.is_jal)
            next_pc = alu_result;
        else if (dx.is_jalr)
            next_pc = {alu_result[31:1], 1'b0};
        else if (dx.is_branch && take_branch)
            next_pc = pc_imm;
        else
            next_pc = pc_plus4;
    end

    always_comb
    begin
        if (dx.is_jal || dx.is_jalr)
            wb_value = pc_plus4;  // link
        else if (dx.is_lui)
            wb_value = dx.imm;
        else
            wb_value = alu_result;
    end

    // decoder must never flag one word as both jump and branch
    always_comb
    begin
        a_jal_branch: assert (!(dx.is_jal && dx.is_branch))
            else $error("jal and branch decoded together");
    end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_core (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] inst,
    output logic [31:0] pc,
    output logic        halted,
    output logic [31:0] trap_value
);

    dec_exec_if dx ();

    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] a0_value;
    logic [31:0] wb_value;
    logic [31:0] next_pc;
    logic        wb_wen;

    assign wb_wen     = dx.reg_wen && !halted;  // freeze state once stopped
    assign trap_value = a0_value;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            pc     <= `RV_RESET_PC;
            halted <= 1'b0;
        end
        else if (!halted)
        begin
            pc <= next_pc;
            if (dx.is_ebreak)
                halted <= 1'b1;
        end
    end

    inst_decoder i_dec (
        .inst (inst),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .dx   (dx.dec)
    );

    reg_file i_rf (
        .clk       (clk),
        .rst       (rst),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .wen       (wb_wen),
        .rd_value  (wb_value),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .a0_value  (a0_value)
    );

    exec_unit i_exe (
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .dx        (dx.exe),
        .wb_value  (wb_value),
        .next_pc   (next_pc)
    );

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst) pc[1:0] == 2'b00)
        else $error("pc lost word alignment");

endmodule

//--- tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_rv_core;

    localparam int OP_IMM = 'b0010011;
    localparam int OP_REG = 'b0110011;
    localparam int LUI    = 'b0110111;
    localparam int JALR   = 'b1100111;
    localparam int ROM_WORDS = 128;

    logic        clk;
    logic        rst;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        halted;
    logic [31:0] trap_value;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] lfsr_state = 32'd66170;
    int          wp;  // next free rom slot
    int          errors;
    int          checks;

    rv_core i_dut (
        .clk        (clk),
        .rst        (rst),
        .inst       (inst),
        .pc         (pc),
        .halted     (halted),
        .trap_value (trap_value)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - `RV_RESET_PC;
        if (off < 32'd512)
            return rom[off[8:2]];
        return 32'h0;  // opcode 0 runs as a no-op
    endfunction

    // instruction memory answers on the falling edge
    initial
    begin
        inst = '0;
        forever
        begin
            @(negedge clk);
            inst <= fetch_word(pc);
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] r_word(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG[6:0]};
    endfunction

    function automatic logic [31:0] i_word(input int opc, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] b_word(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] j_word(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic lt_signed(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic logic [31:0] alu_ref(input int f3, input int alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh   = b[4:0];
        fill = (alt != 0 && a[31]) ? 32'hffff_ffff : 32'h0;
        case (f3)
            0:       return (alt != 0) ? a - b : a + b;
            1:       return a << sh;
            2:       return {31'b0, lt_signed(a, b)};
            3:       return {31'b0, a < b};
            4:       return a ^ b;
            5:       return (a >> sh) | (~(32'hffff_ffff >> sh) & fill);  // sign bits refilled
            6:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input int f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return lt_signed(a, b);
            5:       return !lt_signed(a, b);
            6:       return a < b;
            7:       return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] addr_of(input int idx);
        logic [31:0] off;
        off = idx;
        return `RV_RESET_PC + (off << 2);
    endfunction

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // unused slots hold addi x0 with the slot index
    task automatic clear_rom();
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = i_word(OP_IMM, 0, 0, 0, i);
        wp = 0;
    endtask

    task automatic emit(input logic [31:0] w);
        rom[wp] = w;
        wp++;
    endtask

    task automatic load_const(input int rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;  // addi sign extends the low part
        emit({hi[31:12], rd[4:0], LUI[6:0]});
        emit(i_word(OP_IMM, 0, rd, rd, v));
    endtask

    task automatic pulse_reset();
        @(negedge clk);
        rst <= 1'b0;
        repeat (3) @(negedge clk);
        rst <= 1'b1;
    endtask

    task automatic wait_halt(input string name, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < 200 && !ok; n++)
        begin
            @(negedge clk);
            ok = halted;
        end
        if (!ok)
        begin
            errors++;
            $display("test %s timed out, the core did not halt within 200 cycles", name);
        end
    endtask

    // appends the ebreak, runs from reset and checks a0 and the halt address
    task automatic run_and_check(input string name, input logic [31:0] exp_a0);
        int  halt_idx;
        bit  ok;
        halt_idx = wp;
        emit(`RV_EBREAK);
        pulse_reset();
        expect_eq({name, " halted after reset"}, {31'b0, halted}, 32'd0);
        wait_halt(name, ok);
        if (ok)
        begin
            expect_eq({name, " a0"}, trap_value, exp_a0);
            expect_eq({name, " halt pc"}, pc, addr_of(halt_idx));
        end
    endtask

    task automatic reset_and_halt();
        clear_rom();
        run_and_check("reset_and_halt", 32'h0);
    endtask

    task automatic imm_alu_ops();
        logic [31:0] c1;
        logic [31:0] c2;
        logic [31:0] imm;
        logic [31:0] acc;
        int          k;
        int          f3;
        int          alt;
        clear_rom();
        c1 = rand_bits(32);
        c2 = rand_bits(32);
        load_const(5, c1);
        load_const(6, c2);
        acc = '0;
        for (k = 0; k < 9; k++)
        begin
            f3  = (k == 8) ? 5 : k;
            alt = (k == 8) ? 1 : 0;  // srai last
            if (f3 == 1 || f3 == 5)
                imm = (alt << 10) | rand_bits(5);
            else
                imm = rand_bits(12);
            emit(i_word(OP_IMM, f3, 7, k[0] ? 6 : 5, imm));
            emit(r_word(0, 7, 10, 4, 10));  // a0 ^= x7
            acc = acc ^ alu_ref(f3, alt, k[0] ? c2 : c1, {{20{imm[11]}}, imm[11:0]});
        end
        run_and_check("imm_alu_ops", acc);
    endtask

    task automatic reg_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] acc;
        int          k;
        int          f3;
        int          alt;
        clear_rom();
        acc = '0;
        for (k = 0; k < 10; k++)
        begin
            f3  = (k < 8) ? k : ((k == 8) ? 0 : 5);  // sub, then sra
            alt = (k >= 8) ? 1 : 0;
            a   = rand_bits(32);
            b   = rand_bits(32);
            load_const(5, a);
            load_const(6, b);
            emit(r_word(alt << 5, 6, 5, f3, 7));
            emit(r_word(0, 7, 10, 4, 10));
            acc = acc ^ alu_ref(f3, alt, a, b);
        end
        run_and_check("reg_alu_ops", acc);
    endtask

    task automatic branch_loop_and_mask();
        logic [31:0] n;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pick;
        logic [31:0] exp;
        int          j;
        int          f3;
        clear_rom();
        n = rand_bits(3) + 32'd1;
        emit(i_word(OP_IMM, 0, 6, 0, n));  // x6 counts down from n
        emit(r_word(0, 6, 10, 0, 10));
        emit(i_word(OP_IMM, 0, 6, 6, -1));
        emit(b_word(1, 6, 0, -8));          // bne back to the add
        exp = (n * (n + 32'd1)) >> 1;
        for (j = 0; j < 5; j++)
        begin
            f3   = (j == 0) ? 0 : j + 3;     // beq blt bge bltu bgeu
            a    = rand_bits(32);
            b    = rand_bits(32);
            pick = rand_bits(2);
            if (pick == 32'd3)
                b = a;
            load_const(5, a);
            load_const(6, b);
            emit(b_word(f3, 5, 6, 8));       // taken lands on the ori
            emit(j_word(0, 8));
            emit(i_word(OP_IMM, 6, 10, 10, 64 << j));
            if (branch_ref(f3, a, b))
                exp = exp | (32'd64 << j);
        end
        run_and_check("branch_loop_and_mask", exp);
    endtask

    task automatic jumps_and_x0();
        clear_rom();
        emit(i_word(OP_IMM, 0, 0, 0, 'h55));  // write to x0
        emit(j_word(0, 8));
        emit(i_word(OP_IMM, 0, 10, 0, -1));   // poison
        emit(j_word(1, 12));                  // call, x1 = slot 4
        emit(r_word(0, 0, 1, 0, 10));         // a0 = x1 + x0
        emit(j_word(0, 12));
        emit(i_word(JALR, 0, 0, 1, 1));       // odd target, bit 0 dropped
        emit(i_word(OP_IMM, 0, 10, 0, 'h7ff));
        run_and_check("jumps_and_x0", addr_of(4));
    endtask

    initial
    begin
        rst    = 1'b0;
        errors = 0;
        checks = 0;
        wp     = 0;
        reset_and_halt();
        imm_alu_ops();
        reg_alu_ops();
        branch_loop_and_mask();
        jumps_and_x0();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- flist.f
+incdir+.
rv_pkg.sv
dec_exec_if.sv
inst_decoder.sv
reg_file.sv
exec_unit.sv
rv_core.sv
tb_rv_core.sv

//--- Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert
TOP      := tb_rv_core
FLIST    := flist.f
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(filter-out +%,$(shell cat $(FLIST))) rv_macros.svh

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

clean:
	rm -rf $(OBJDIR)
